// File: src/blur_pkg.sv
package blur_pkg;

  // image geometry
  localparam int pix_w       = 8;
  localparam int strip_pix   = 16;
  localparam int halo_pix    = strip_pix + 2;
  localparam int num_strips  = 4;
  localparam int num_rows    = 8;
  localparam int row_w       = $clog2(num_rows);
  localparam int strip_idx_w = $clog2(num_strips);
  localparam int word_w      = num_strips * strip_pix * pix_w;

  // writeback lag after the last request of a strip
  localparam int drain_cycles = 2;
  localparam int drain_w      = $clog2(drain_cycles);

  // kernel arithmetic widths, column sum 1-2-1 then row sum 1-2-1
  localparam int col_w = pix_w + 2;
  localparam int sum_w = pix_w + 4;

  localparam logic [row_w-1:0]       row_last   = row_w'(num_rows - 1);
  localparam logic [strip_idx_w-1:0] strip_last = strip_idx_w'(num_strips - 1);
  localparam logic [drain_w-1:0]     drain_last = drain_w'(drain_cycles - 1);

  typedef logic [pix_w-1:0] pixel_t;
  typedef pixel_t [strip_pix-1:0] strip_t;
  typedef pixel_t [halo_pix-1:0] halo_row_t;

  typedef struct packed {
    halo_row_t row_top;
    halo_row_t row_mid;
    halo_row_t row_bot;
  } line_win_t;

  // slot 0 sits in the low bits of the stored word
  typedef union packed {
    logic [word_w-1:0]         flat;
    strip_t [num_strips-1:0]   slots;
  } blur_word_u;

  typedef struct packed {
    logic                   valid;
    logic [row_w-1:0]       row;
    logic [strip_idx_w-1:0] strip;
  } rd_req_t;

  typedef struct packed {
    logic             we;
    logic [row_w-1:0] addr;
    blur_word_u       data;
  } blur_wr_t;

endpackage

// File: src/blur_ctrl.sv
`timescale 1ns/1ps

module blur_ctrl (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              start,
  input  logic              wr_last,
  output blur_pkg::rd_req_t rd_req,
  output logic              done
);

  typedef enum logic [1:0] {
    st_idle,
    st_prime,
    st_row,
    st_drain
  } state_t;

  state_t                             state;
  state_t                             state_nxt;
  logic [blur_pkg::row_w-1:0]         row_cnt;
  logic [blur_pkg::strip_idx_w-1:0]   strip_cnt;
  logic [blur_pkg::drain_w-1:0]       drain_cnt;
  logic                               last_row;
  logic                               last_strip;
  logic                               drain_end;

  assign last_row   = row_cnt == blur_pkg::row_last;
  assign last_strip = strip_cnt == blur_pkg::strip_last;
  assign drain_end  = drain_cnt == blur_pkg::drain_last;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= st_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle: begin
        if (start) begin
          state_nxt = st_prime;
        end
      end
      // one idle slot so the memories see a clean first request
      st_prime: begin
        state_nxt = st_row;
      end
      st_row: begin
        if (last_row) begin
          state_nxt = st_drain;
        end
      end
      st_drain: begin
        if (drain_end) begin
          state_nxt = last_strip ? st_idle : st_prime;
        end
      end
      default: begin
        state_nxt = st_idle;
      end
    endcase
  end

  // row counter wraps back to 0 after the last row of a strip
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      row_cnt <= '0;
    end else if (state == st_row) begin
      row_cnt <= last_row ? '0 : row_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      strip_cnt <= '0;
    end else if (state == st_idle) begin
      strip_cnt <= '0;
    end else if (state == st_drain && drain_end && !last_strip) begin
      strip_cnt <= strip_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      drain_cnt <= '0;
    end else if (state == st_drain) begin
      drain_cnt <= drain_cnt + 1'b1;
    end else begin
      drain_cnt <= '0;
    end
  end

  // set by the final write, cleared by a fresh start
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (wr_last) begin
      done <= 1'b1;
    end else if (state == st_idle && start) begin
      done <= 1'b0;
    end
  end

  always_comb begin
    rd_req.valid = state == st_row;
    rd_req.row   = row_cnt;
    rd_req.strip = strip_cnt;
  end

endmodule

// File: src/gauss_kernel_3x3.sv
`timescale 1ns/1ps

module gauss_kernel_3x3 (
  input  blur_pkg::line_win_t win,
  output blur_pkg::strip_t    result
);

  // separable form of 1 2 1 / 2 4 2 / 1 2 1
  // vertical 1-2-1 per column first, then horizontal 1-2-1 over columns
  logic [blur_pkg::col_w-1:0] col_sum [blur_pkg::halo_pix];

  for (genvar j = 0; j < blur_pkg::halo_pix; j++) begin : g_col
    logic [blur_pkg::col_w-1:0] top_ext;
    logic [blur_pkg::col_w-1:0] mid_dbl;
    logic [blur_pkg::col_w-1:0] bot_ext;

    assign top_ext = {2'b00, win.row_top[j]};
    assign mid_dbl = {1'b0, win.row_mid[j], 1'b0};
    assign bot_ext = {2'b00, win.row_bot[j]};

    // at most 4 * 255, fits col_w
    assign col_sum[j] = top_ext + mid_dbl + bot_ext;
  end

  for (genvar i = 0; i < blur_pkg::strip_pix; i++) begin : g_pix
    logic [blur_pkg::sum_w-1:0] left_ext;
    logic [blur_pkg::sum_w-1:0] cent_dbl;
    logic [blur_pkg::sum_w-1:0] right_ext;
    logic [blur_pkg::sum_w-1:0] pix_sum;

    // output pixel i is centred on halo position i+1
    assign left_ext  = {2'b00, col_sum[i]};
    assign cent_dbl  = {1'b0, col_sum[i+1], 1'b0};
    assign right_ext = {2'b00, col_sum[i+2]};

    assign pix_sum = left_ext + cent_dbl + right_ext;

    // divide by 16, truncated
    assign result[i] = pix_sum[blur_pkg::sum_w-1 -: blur_pkg::pix_w];
  end

endmodule

// File: src/strip_merge.sv
`timescale 1ns/1ps

module strip_merge (
  input  logic                 clk,
  input  logic                 rst_n,
  input  blur_pkg::rd_req_t    rd_req,
  input  blur_pkg::strip_t     result,
  input  blur_pkg::blur_word_u blur_dout,
  output blur_pkg::blur_wr_t   blur_wr,
  output logic                 wr_last
);

  blur_pkg::rd_req_t    req_q;
  blur_pkg::blur_word_u merged;
  logic                 final_req;

  // memories answer one cycle after the request, so hold it one cycle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      req_q <= '0;
    end else begin
      req_q <= rd_req;
    end
  end

  // slots below the strip keep stored data, slots above are cleared
  always_comb begin
    for (int s = 0; s < blur_pkg::num_strips; s++) begin
      if (s < req_q.strip) begin
        merged.slots[s] = blur_dout.slots[s];
      end else if (s == req_q.strip) begin
        merged.slots[s] = result;
      end else begin
        merged.slots[s] = '0;
      end
    end
  end

  assign final_req = req_q.valid
                     && req_q.row == blur_pkg::row_last
                     && req_q.strip == blur_pkg::strip_last;

  // write goes out two cycles after the request
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      blur_wr.we        <= 1'b0;
      blur_wr.addr      <= '0;
      blur_wr.data.flat <= '0;
      wr_last           <= 1'b0;
    end else begin
      blur_wr.we <= req_q.valid;
      wr_last    <= final_req;
      // data and address only move on a real request
      if (req_q.valid) begin
        blur_wr.addr <= req_q.row;
        blur_wr.data <= merged;
      end
    end
  end

endmodule

// File: src/gauss_blur_top.sv
`timescale 1ns/1ps

module gauss_blur_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 start,
  input  blur_pkg::line_win_t  win,
  input  blur_pkg::blur_word_u blur_dout,
  output blur_pkg::rd_req_t    rd_req,
  output blur_pkg::blur_wr_t   blur_wr,
  output logic                 done
);

  // kernel output for the window returned this cycle
  blur_pkg::strip_t result;

  // final row of final strip is being written
  logic wr_last;

  blur_ctrl blur_ctrl_i (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (start),
    .wr_last (wr_last),
    .rd_req  (rd_req),
    .done    (done)
  );

  gauss_kernel_3x3 gauss_kernel_3x3_i (
    .win    (win),
    .result (result)
  );

  strip_merge strip_merge_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .rd_req    (rd_req),
    .result    (result),
    .blur_dout (blur_dout),
    .blur_wr   (blur_wr),
    .wr_last   (wr_last)
  );

endmodule

// File: tests/gauss_blur_asserts.sv
`timescale 1ns/1ps

module gauss_blur_asserts (
  input logic               clk,
  input logic               rst_n,
  input logic               start,
  input logic               done,
  input blur_pkg::rd_req_t  rd_req,
  input blur_pkg::blur_wr_t blur_wr
);

  // request at t, write of the same row at t+2
  property req_to_write;
    @(posedge clk) disable iff (!rst_n)
      rd_req.valid |-> ##2 (blur_wr.we && blur_wr.addr == $past(rd_req.row, 2));
  endproperty

  // done only drops right after a start
  property done_falls_on_start;
    @(posedge clk) disable iff (!rst_n)
      $fell(done) |-> $past(start);
  endproperty

  // writes of one strip come back to back, no holes
  property strip_writes_contiguous;
    @(posedge clk) disable iff (!rst_n)
      $rose(blur_wr.we) |-> blur_wr.we [*blur_pkg::num_rows] ##1 !blur_wr.we;
  endproperty

  assert property (req_to_write)
    else $error("request was not followed by a write of its row two cycles later");

  assert property (done_falls_on_start)
    else $error("done fell without a start in the previous cycle");

  assert property (strip_writes_contiguous)
    else $error("writes of one strip were not contiguous");

endmodule

bind gauss_blur_top gauss_blur_asserts gauss_blur_asserts_i (
  .clk     (clk),
  .rst_n   (rst_n),
  .start   (start),
  .done    (done),
  .rd_req  (rd_req),
  .blur_wr (blur_wr)
);

// File: tests/gauss_blur_tb.sv
`timescale 1ns/1ps

module gauss_blur_tb;

  localparam int clk_half_ns  = 4;
  localparam int reset_cycles = 16;
  localparam int img_cols     = blur_pkg::num_strips * blur_pkg::strip_pix;
  localparam int strip_cycles = 1 + blur_pkg::num_rows + 2;
  localparam int frame_cycles = blur_pkg::num_strips * strip_cycles;
  localparam int frame_writes = blur_pkg::num_strips * blur_pkg::num_rows;
  localparam int frame_gap    = 32;
  localparam int num_frames   = 7;
  localparam int run_cycles   = reset_cycles + num_frames * (frame_cycles + frame_gap);

  typedef struct packed {
    int cyc;
    int row;
    int strip;
  } req_rec_t;

  logic                 clk;
  logic                 rst_n;
  logic                 start;
  blur_pkg::line_win_t  win;
  blur_pkg::blur_word_u blur_dout;
  blur_pkg::rd_req_t    rd_req;
  blur_pkg::blur_wr_t   blur_wr;
  logic                 done;

  blur_pkg::pixel_t     img [blur_pkg::num_rows][img_cols];
  blur_pkg::pixel_t     blurred [blur_pkg::num_rows][img_cols];
  blur_pkg::blur_word_u sram [blur_pkg::num_rows];

  // monitor state
  req_rec_t req_q [$];
  int       cyc;
  int       start_cyc;
  int       done_cyc;
  int       wr_count;
  int       req_count;
  logic     busy;
  logic     done_q;
  logic     check_words;
  logic     check_merge;

  gauss_blur_top gauss_blur_top_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .win       (win),
    .blur_dout (blur_dout),
    .rd_req    (rd_req),
    .blur_wr   (blur_wr),
    .done      (done)
  );

  always #(clk_half_ns) clk = ~clk;

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation failed");
    $fatal(1, "run stopped on first error");
  endtask

  task automatic check_value(input string name, input logic [511:0] actual,
                             input logic [511:0] expected);
    if (actual !== expected) begin
      $display("CHECK FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      abort_run($sformatf("value of %s is wrong", name));
    end
  endtask

  // zero outside the image
  function automatic blur_pkg::pixel_t pixel_at(input int r, input int c);
    if (r < 0 || r >= blur_pkg::num_rows || c < 0 || c >= img_cols) begin
      return '0;
    end
    return img[r][c];
  endfunction

  // direct 2d weighted sum with weights 1 2 1 / 2 4 2 / 1 2 1
  function automatic blur_pkg::pixel_t blur_pixel(input int r, input int c);
    int sum;
    sum = 0;
    for (int dr = -1; dr <= 1; dr++) begin
      for (int dc = -1; dc <= 1; dc++) begin
        sum += (dr == 0 ? 2 : 1) * (dc == 0 ? 2 : 1) * int'(pixel_at(r + dr, c + dc));
      end
    end
    return blur_pkg::pixel_t'(sum >> 4);
  endfunction

  // halo position j maps to image column strip*16 + j - 1
  function automatic blur_pkg::line_win_t window_at(input int r, input int s);
    blur_pkg::line_win_t w;
    for (int j = 0; j < blur_pkg::halo_pix; j++) begin
      w.row_top[j] = pixel_at(r - 1, s * blur_pkg::strip_pix + j - 1);
      w.row_mid[j] = pixel_at(r, s * blur_pkg::strip_pix + j - 1);
      w.row_bot[j] = pixel_at(r + 1, s * blur_pkg::strip_pix + j - 1);
    end
    return w;
  endfunction

  // word after strip s of row r with later strips cleared
  function automatic blur_pkg::blur_word_u expected_word(input int r, input int s);
    blur_pkg::blur_word_u w;
    for (int k = 0; k < blur_pkg::num_strips; k++) begin
      for (int i = 0; i < blur_pkg::strip_pix; i++) begin
        w.slots[k][i] = (k <= s) ? blurred[r][k * blur_pkg::strip_pix + i] : '0;
      end
    end
    return w;
  endfunction

  task automatic load_image(input logic use_const, input blur_pkg::pixel_t v);
    for (int r = 0; r < blur_pkg::num_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        img[r][c] = use_const ? v : blur_pkg::pixel_t'($urandom);
      end
    end
    for (int r = 0; r < blur_pkg::num_rows; r++) begin
      for (int c = 0; c < img_cols; c++) begin
        blurred[r][c] = blur_pixel(r, c);
      end
    end
  endtask

  // stale content that differs in every byte of every row
  task automatic fill_sram();
    for (int r = 0; r < blur_pkg::num_rows; r++) begin
      for (int b = 0; b < img_cols; b++) begin
        sram[r].flat[b * 8 +: 8] = 8'(b * 3 + r * 41 + 7);
      end
    end
  endtask

  // line buffer and blur sram answer one cycle after a request
  always @(posedge clk) begin
    if (rd_req.valid) begin
      win       <= window_at(rd_req.row, rd_req.strip);
      blur_dout <= sram[rd_req.row];
    end
    if (blur_wr.we) begin
      sram[blur_wr.addr] <= blur_wr.data;
    end
  end

  always @(posedge clk) begin : monitor
    req_rec_t             req;
    blur_pkg::blur_word_u exp_word;
    if (rst_n) begin
      cyc = cyc + 1;
      if (start && !busy) begin
        busy      = 1'b1;
        start_cyc = cyc;
        wr_count  = 0;
        req_count = 0;
      end
      if (done && !done_q && busy) begin
        busy     = 1'b0;
        done_cyc = cyc;
      end
      done_q = done;
      // rows run 0 to 7 within a strip, strips run 0 to 3
      if (rd_req.valid) begin
        req.cyc   = cyc;
        req.row   = req_count % blur_pkg::num_rows;
        req.strip = req_count / blur_pkg::num_rows;
        check_value("rd_req.row", rd_req.row, req.row);
        check_value("rd_req.strip", rd_req.strip, req.strip);
        // prime cycle before each strip and two drain cycles after it
        check_value("request cycle", cyc - start_cyc,
                    2 + req.strip * strip_cycles + req.row);
        req_count++;
        req_q.push_back(req);
      end
      if (blur_wr.we && req_q.size() == 0) begin
        abort_run("write seen with no outstanding request");
      end else if (blur_wr.we) begin
        req = req_q.pop_front();
        check_value("write lag", cyc - req.cyc, 2);
        check_value("blur_wr.addr", blur_wr.addr, req.row);
        if (check_words) begin
          exp_word = expected_word(req.row, req.strip);
          check_value("blur_wr.data", blur_wr.data.flat, exp_word.flat);
        end
        // sram still holds the previous word at this edge
        for (int k = 0; k < blur_pkg::num_strips; k++) begin
          if (check_merge && k < req.strip) begin
            check_value($sformatf("blur_wr.data.slots[%0d]", k), blur_wr.data.slots[k],
                        sram[req.row].slots[k]);
          end else if (check_merge && k > req.strip) begin
            check_value($sformatf("blur_wr.data.slots[%0d]", k), blur_wr.data.slots[k], '0);
          end
        end
        wr_count++;
      end
    end
  end

  task automatic pulse_start();
    @(posedge clk);
    start <= 1'b1;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done();
    @(negedge clk);
    while (!done) begin
      @(negedge clk);
    end
    // let the monitor settle on the final edge
    repeat (2) @(negedge clk);
  endtask

  task automatic check_frame();
    blur_pkg::blur_word_u w;
    check_value("writes per frame", wr_count, frame_writes);
    check_value("open requests", req_q.size(), 0);
    for (int r = 0; r < blur_pkg::num_rows; r++) begin
      w = expected_word(r, blur_pkg::num_strips - 1);
      check_value($sformatf("sram[%0d]", r), sram[r].flat, w.flat);
    end
  endtask

  // done is registered one edge before the monitor sees it
  task automatic check_frame_length();
    check_value("frame cycles", done_cyc - 1 - start_cyc, frame_cycles);
  endtask

  task automatic test_reset_state();
    @(negedge clk);
    check_value("done", done, 1'b0);
    check_value("rd_req.valid", rd_req.valid, 1'b0);
    check_value("blur_wr.we", blur_wr.we, 1'b0);
    check_value("blur_wr.data", blur_wr.data.flat, '0);
  endtask

  task automatic test_constant_image();
    load_image(1'b1, 8'hc8);
    fill_sram();
    check_words = 1'b1;
    pulse_start();
    wait_done();
    check_words = 1'b0;
    check_frame();
    // away from the border the blur of a flat image is the image
    for (int r = 1; r < blur_pkg::num_rows - 1; r++) begin
      for (int c = 1; c < img_cols - 1; c++) begin
        check_value($sformatf("sram[%0d] pixel %0d", r, c), sram[r].flat[c * 8 +: 8], 8'hc8);
      end
    end
  endtask

  task automatic test_random_frame();
    load_image(1'b0, '0);
    fill_sram();
    check_words = 1'b1;
    pulse_start();
    wait_done();
    check_words = 1'b0;
    check_frame();
  endtask

  task automatic test_merge_rule();
    load_image(1'b0, '0);
    fill_sram();
    check_merge = 1'b1;
    pulse_start();
    wait_done();
    check_merge = 1'b0;
    check_frame();
  endtask

  task automatic test_timing_and_done();
    load_image(1'b0, '0);
    pulse_start();
    wait_done();
    check_frame_length();
    repeat (10) begin
      @(negedge clk);
      check_value("done", done, 1'b1);
    end
    pulse_start();
    @(negedge clk);
    check_value("done", done, 1'b0);
    wait_done();
    check_frame_length();
    check_frame();
  endtask

  task automatic test_back_to_back();
    load_image(1'b0, '0);
    fill_sram();
    check_words = 1'b1;
    pulse_start();
    repeat (20) @(posedge clk);
    // mid frame start is ignored
    pulse_start();
    wait_done();
    check_frame_length();
    check_frame();
    load_image(1'b0, '0);
    pulse_start();
    wait_done();
    check_words = 1'b0;
    check_frame_length();
    check_frame();
  endtask

  initial begin
    #(3 * run_cycles * 2 * clk_half_ns);
    abort_run($sformatf("timeout: tests did not finish within %0d cycles", 3 * run_cycles));
  end

  initial begin
    void'($urandom(21636));
    clk         = 1'b0;
    rst_n       = 1'b0;
    start       = 1'b0;
    win         = '0;
    blur_dout   = '0;
    cyc         = 0;
    start_cyc   = 0;
    done_cyc    = 0;
    wr_count    = 0;
    req_count   = 0;
    busy        = 1'b0;
    done_q      = 1'b0;
    check_words = 1'b0;
    check_merge = 1'b0;
    repeat (reset_cycles) @(posedge clk);
    rst_n <= 1'b1;
    test_reset_state();
    test_constant_image();
    test_random_frame();
    test_merge_rule();
    test_timing_and_done();
    test_back_to_back();
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: compile.f
src/blur_pkg.sv
src/blur_ctrl.sv
src/gauss_kernel_3x3.sv
src/strip_merge.sv
src/gauss_blur_top.sv
tests/gauss_blur_asserts.sv
tests/gauss_blur_tb.sv

// File: Bender.yml
package:
  name: gauss_blur

sources:
  - files:
      - src/blur_pkg.sv
      - src/blur_ctrl.sv
      - src/gauss_kernel_3x3.sv
      - src/strip_merge.sv
      - src/gauss_blur_top.sv
  - target: test
    files:
      - tests/gauss_blur_asserts.sv
      - tests/gauss_blur_tb.sv
